/* vlog.f */
+incdir+include
design/id_remap_pkg.sv
design/remap_table_if.sv
design/ar_remap.sv
design/remap_table.sv
design/r_unmap.sv
design/slv_id_remap.sv
dv/slv_id_remap_asserts.sv
dv/tb_slv_id_remap.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_slv_id_remap
RTL_TOP   ?= slv_id_remap
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_slv_id_remap.sv */
`timescale 1ns/100ps
`default_nettype none

`include "id_remap_defines.svh"

module tb_slv_id_remap;

  localparam int N_TESTS   = 3;
  localparam int SEED      = 29;
  localparam int MAX_BEATS = 8;
  localparam int N_REQ     [N_TESTS] = '{40, 40, 30};
  localparam int ID_MOD    [N_TESTS] = '{0, 3, 0}; // Zero gives the full ID range.
  localparam int AR_PCT    [N_TESTS] = '{70, 80, 90};
  localparam int START_PCT [N_TESTS] = '{50, 50, 4};
  localparam int RDY_PCT   [N_TESTS] = '{70, 50, 60};
  localparam int TIMEOUT_CYCLES = 20 * MAX_BEATS * (40 + 40 + 30); // Upper bound on all beats.

  typedef struct packed {
    id_remap_pkg::remap_id_t  id;
    id_remap_pkg::out_addr_t  addr;
    logic [7:0]               len;
    logic [2:0]               size;
    id_remap_pkg::axi_burst_e burst;
    logic [2:0]               prot;
  } ar_item_t;

  typedef struct packed {
    id_remap_pkg::orig_id_t  id;
    id_remap_pkg::data_t     data;
    id_remap_pkg::axi_resp_e resp;
    logic                    last;
  } r_item_t;

  logic                     clk_i, reset_i;
  id_remap_pkg::orig_id_t   slv_ar_id_i, slv_r_id_o;
  id_remap_pkg::in_addr_t   slv_ar_addr_i;
  logic [7:0]               slv_ar_len_i, mst_ar_len_o;
  logic [2:0]               slv_ar_size_i, slv_ar_prot_i, mst_ar_size_o, mst_ar_prot_o;
  id_remap_pkg::axi_burst_e slv_ar_burst_i, mst_ar_burst_o;
  logic                     slv_ar_valid_i, slv_ar_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  id_remap_pkg::data_t      slv_r_data_o, mst_r_data_i;
  id_remap_pkg::axi_resp_e  slv_r_resp_o, mst_r_resp_i;
  logic                     slv_r_last_o, slv_r_valid_o, slv_r_ready_i;
  id_remap_pkg::remap_id_t  mst_ar_id_o, mst_r_id_i;
  id_remap_pkg::out_addr_t  mst_ar_addr_o;
  logic                     mst_r_last_i, mst_r_valid_i, mst_r_ready_o;

  // Scoreboard of slots, expected traffic and the memory's request list.
  logic                   slot_busy [`N_SLOTS];
  id_remap_pkg::orig_id_t slot_orig [`N_SLOTS];
  ar_item_t               exp_ar [$];
  ar_item_t               pend [$];
  r_item_t                exp_r [$];
  ar_item_t               act_item;
  logic                   act_on;
  int                     act_beat, cur, sent_cnt, done_cnt, err_cnt, check_cnt, cycle_cnt;
  string                  test_name [N_TESTS] = '{"unique_ids", "repeat_ids", "slow_memory"};

  slv_id_remap slv_id_remap_i (.*);

  bind slv_id_remap slv_id_remap_asserts asserts_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .mst_ar_valid_i (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_ar_id_i    (mst_ar_id_o),
    .mst_ar_addr_i  (mst_ar_addr_o),
    .mst_ar_len_i   (mst_ar_len_o),
    .slv_r_valid_i  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .slv_r_id_i     (slv_r_id_o),
    .slv_r_data_i   (slv_r_data_o),
    .slv_r_last_i   (slv_r_last_o)
  );

  task automatic expect_eq(input string name, input logic [127:0] got, input logic [127:0] want);
    check_cnt++;
    if (got !== want) begin
      $display("FAILED t=%0t %s got %0h expected %0h", $time, name, got, want);
      err_cnt++;
    end
  endtask

  task automatic report(input string what);
    $display("Error at t=%0t: %s", $time, what);
    err_cnt++;
  endtask

  function automatic id_remap_pkg::data_t beat_data(input id_remap_pkg::out_addr_t addr,
                                                    input int beat);
    return {addr, 32'hda7a_0000, 24'd0, 8'(beat)};
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    logic     ar_taken, r_taken, in_reset;
    int       slot, pick;
    ar_item_t want_ar, got_ar;
    r_item_t  beat;
    ar_taken = slv_ar_valid_i && slv_ar_ready_o;
    r_taken  = mst_r_valid_i && mst_r_ready_o;
    in_reset = reset_i;
    if (!in_reset) begin
      if (ar_taken) begin
        slot = -1;
        for (int i = 0; i < `N_SLOTS; i++) begin
          if (slot < 0 && !slot_busy[i]) slot = i; // Lowest free slot.
          if (slot_busy[i] && slot_orig[i] == slv_ar_id_i) begin
            report("request accepted while its original ID is in flight");
          end
        end
        if (slot < 0) begin
          report("request accepted while all four slots are busy");
        end else begin
          slot_busy[slot] = 1'b1;
          slot_orig[slot] = slv_ar_id_i;
          want_ar.id    = 4'(slot);
          want_ar.addr  = 64'(slv_ar_addr_i);
          want_ar.len   = slv_ar_len_i;
          want_ar.size  = slv_ar_size_i;
          want_ar.burst = slv_ar_burst_i;
          want_ar.prot  = slv_ar_prot_i;
          exp_ar.push_back(want_ar);
        end
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        got_ar = {mst_ar_id_o, mst_ar_addr_o, mst_ar_len_o, mst_ar_size_o, mst_ar_burst_o,
                  mst_ar_prot_o};
        if (exp_ar.size() == 0) begin
          report("request on mst_ar with none expected");
        end else begin
          want_ar = exp_ar.pop_front();
          expect_eq("mst_ar_id_o", 128'(got_ar.id), 128'(want_ar.id));
          expect_eq("mst_ar_addr_o", 128'(got_ar.addr), 128'(want_ar.addr));
          expect_eq("mst_ar_len_o", 128'(got_ar.len), 128'(want_ar.len));
          expect_eq("mst_ar_size_o", 128'(got_ar.size), 128'(want_ar.size));
          expect_eq("mst_ar_burst_o", 128'(got_ar.burst), 128'(want_ar.burst));
          expect_eq("mst_ar_prot_o", 128'(got_ar.prot), 128'(want_ar.prot));
        end
        if (pend.size() + int'(act_on) >= `N_SLOTS) report("more than four requests outstanding");
        foreach (pend[k]) begin
          if (pend[k].id == got_ar.id) report("downstream ID reused while outstanding");
        end
        if (act_on && act_item.id == got_ar.id) report("downstream ID reused while outstanding");
        pend.push_back(got_ar);
      end
      if (r_taken) begin
        beat.id   = slot_orig[mst_r_id_i[`SLOT_W-1:0]];
        beat.data = mst_r_data_i;
        beat.resp = mst_r_resp_i;
        beat.last = mst_r_last_i;
        exp_r.push_back(beat);
        act_beat++;
        if (mst_r_last_i) begin
          slot_busy[mst_r_id_i[`SLOT_W-1:0]] = 1'b0; // Slot frees at this edge.
          act_on = 1'b0;
        end
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        if (exp_r.size() == 0) begin
          report("beat on slv_r with none expected");
        end else begin
          beat = exp_r.pop_front();
          expect_eq("slv_r_id_o", 128'(slv_r_id_o), 128'(beat.id));
          expect_eq("slv_r_data_o", slv_r_data_o, beat.data);
          expect_eq("slv_r_resp_o", 128'(slv_r_resp_o), 128'(beat.resp));
          expect_eq("slv_r_last_o", 128'(slv_r_last_o), 128'(beat.last));
          if (beat.last) done_cnt++;
        end
      end
    end
    #1;
    if (!slv_ar_valid_i || ar_taken) begin
      slv_ar_valid_i = 1'b0;
      if (!in_reset && sent_cnt < N_REQ[cur] && ($urandom % 100) < AR_PCT[cur]) begin
        slv_ar_id_i    = (ID_MOD[cur] == 0) ? 17'($urandom) : 17'($urandom % ID_MOD[cur]);
        slv_ar_addr_i  = {8'($urandom), $urandom};
        slv_ar_len_i   = 8'($urandom % MAX_BEATS);
        slv_ar_size_i  = 3'($urandom);
        slv_ar_burst_i = id_remap_pkg::axi_burst_e'(2'($urandom % 3));
        slv_ar_prot_i  = 3'($urandom);
        slv_ar_valid_i = 1'b1;
        sent_cnt++;
      end
    end
    mst_ar_ready_i = ($urandom % 100) < RDY_PCT[cur];
    slv_r_ready_i  = ($urandom % 100) < RDY_PCT[cur];
    // Memory answers one burst at a time, picked at random from its list.
    if (!mst_r_valid_i || r_taken) begin
      mst_r_valid_i = 1'b0;
      if (!act_on && pend.size() > 0 && ($urandom % 100) < START_PCT[cur]) begin
        pick     = int'($urandom % pend.size());
        act_item = pend[pick];
        pend.delete(pick);
        act_on   = 1'b1;
        act_beat = 0;
      end
      if (act_on) begin
        mst_r_id_i    = act_item.id;
        mst_r_data_i  = beat_data(act_item.addr, act_beat);
        mst_r_resp_i  = id_remap_pkg::axi_resp_e'(2'($urandom));
        mst_r_last_i  = (act_beat == int'(act_item.len));
        mst_r_valid_i = 1'b1;
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
    $display("Errors found");
    $finish;
  end

  initial begin
    int errs_before;
    void'($urandom(SEED));
    reset_i        = 1'b1;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_ar_size_i  = '0;
    slv_ar_burst_i = id_remap_pkg::BURST_INCR;
    slv_ar_prot_i  = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = id_remap_pkg::RESP_OKAY;
    mst_r_last_i   = 1'b0;
    mst_r_valid_i  = 1'b0;
    cur       = 0;
    sent_cnt  = 0;
    done_cnt  = 0;
    err_cnt   = 0;
    check_cnt = 0;
    act_on    = 1'b0;
    act_beat  = 0;
    for (int i = 0; i < `N_SLOTS; i++) slot_busy[i] = 1'b0;
    repeat (4) @(posedge clk_i);
    #1 reset_i = 1'b0;
    for (int t = 0; t < N_TESTS; t++) begin
      errs_before = err_cnt;
      cur      = t;
      sent_cnt = 0;
      done_cnt = 0;
      while (done_cnt < N_REQ[t]) @(posedge clk_i);
      #2;
      if (exp_ar.size() != 0 || exp_r.size() != 0 || pend.size() != 0 || act_on) begin
        report("items left over after the last burst completed");
      end
      $display("Test %s done: %0d requests, %0d errors", test_name[t], N_REQ[t],
               err_cnt - errs_before);
    end
    $display("Tests %0d, checks %0d, check errors %0d, assertion failures %0d", N_TESTS,
             check_cnt, err_cnt, slv_id_remap_i.asserts_i.fail_cnt);
    if (err_cnt + slv_id_remap_i.asserts_i.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/slv_id_remap_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

`include "id_remap_defines.svh"

module slv_id_remap_asserts (
  input wire                   clk_i,
  input wire                   reset_i,
  input wire                   mst_ar_valid_i,
  input wire                   mst_ar_ready_i,
  input wire [`REMAP_ID_W-1:0] mst_ar_id_i,
  input wire [`OUT_ADDR_W-1:0] mst_ar_addr_i,
  input wire [7:0]             mst_ar_len_i,
  input wire                   slv_r_valid_i,
  input wire                   slv_r_ready_i,
  input wire [`ORIG_ID_W-1:0]  slv_r_id_i,
  input wire [`DATA_W-1:0]     slv_r_data_i,
  input wire                   slv_r_last_i
);

  int fail_cnt = 0; // Count of failed assertions.

  // A request that is not taken holds valid and payload.
  ar_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_ar_valid_i && !mst_ar_ready_i |=> mst_ar_valid_i && $stable(mst_ar_id_i)
      && $stable(mst_ar_addr_i) && $stable(mst_ar_len_i))
    else begin
      fail_cnt++;
      $error("mst_ar valid or payload changed before the transfer");
    end

  r_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_r_valid_i && !slv_r_ready_i |=> slv_r_valid_i && $stable(slv_r_id_i)
      && $stable(slv_r_data_i) && $stable(slv_r_last_i))
    else begin
      fail_cnt++;
      $error("slv_r valid or payload changed before the transfer");
    end

  ar_id_range_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_ar_valid_i |-> mst_ar_id_i < `N_SLOTS)
    else begin
      fail_cnt++;
      $error("mst_ar ID outside the slot range");
    end

  reset_quiet_a: assert property (@(posedge clk_i)
    reset_i |=> !mst_ar_valid_i && !slv_r_valid_i)
    else begin
      fail_cnt++;
      $error("valid high during reset");
    end

endmodule

`default_nettype wire

/* design/slv_id_remap.sv */
`timescale 1ns/100ps
`default_nettype none

`include "id_remap_defines.svh"

module slv_id_remap (
  input  wire                       clk_i,
  input  wire                       reset_i,
  // Upstream read request.
  input  wire [`ORIG_ID_W-1:0]      slv_ar_id_i,
  input  wire [`IN_ADDR_W-1:0]      slv_ar_addr_i,
  input  wire [7:0]                 slv_ar_len_i,
  input  wire [2:0]                 slv_ar_size_i,
  input  id_remap_pkg::axi_burst_e  slv_ar_burst_i,
  input  wire [2:0]                 slv_ar_prot_i,
  input  wire                       slv_ar_valid_i,
  output logic                      slv_ar_ready_o,
  // Upstream read data.
  output logic [`ORIG_ID_W-1:0]     slv_r_id_o,
  output logic [`DATA_W-1:0]        slv_r_data_o,
  output id_remap_pkg::axi_resp_e   slv_r_resp_o,
  output logic                      slv_r_last_o,
  output logic                      slv_r_valid_o,
  input  wire                       slv_r_ready_i,
  // Downstream read request.
  output logic [`REMAP_ID_W-1:0]    mst_ar_id_o,
  output logic [`OUT_ADDR_W-1:0]    mst_ar_addr_o,
  output logic [7:0]                mst_ar_len_o,
  output logic [2:0]                mst_ar_size_o,
  output id_remap_pkg::axi_burst_e  mst_ar_burst_o,
  output logic [2:0]                mst_ar_prot_o,
  output logic                      mst_ar_valid_o,
  input  wire                       mst_ar_ready_i,
  // Downstream read data.
  input  wire [`REMAP_ID_W-1:0]     mst_r_id_i,
  input  wire [`DATA_W-1:0]         mst_r_data_i,
  input  id_remap_pkg::axi_resp_e   mst_r_resp_i,
  input  wire                       mst_r_last_i,
  input  wire                       mst_r_valid_i,
  output logic                      mst_r_ready_o
);

  remap_table_if tbl_if ();

  ar_remap i_ar_remap (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .slv_ar_id_i    (slv_ar_id_i),
    .slv_ar_addr_i  (slv_ar_addr_i),
    .slv_ar_len_i   (slv_ar_len_i),
    .slv_ar_size_i  (slv_ar_size_i),
    .slv_ar_burst_i (slv_ar_burst_i),
    .slv_ar_prot_i  (slv_ar_prot_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .mst_ar_id_o    (mst_ar_id_o),
    .mst_ar_addr_o  (mst_ar_addr_o),
    .mst_ar_len_o   (mst_ar_len_o),
    .mst_ar_size_o  (mst_ar_size_o),
    .mst_ar_burst_o (mst_ar_burst_o),
    .mst_ar_prot_o  (mst_ar_prot_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .tbl            (tbl_if.requester)
  );

  remap_table i_remap_table (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .tbl     (tbl_if.slot_table)
  );

  r_unmap i_r_unmap (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mst_r_id_i    (mst_r_id_i),
    .mst_r_data_i  (mst_r_data_i),
    .mst_r_resp_i  (mst_r_resp_i),
    .mst_r_last_i  (mst_r_last_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o),
    .slv_r_id_o    (slv_r_id_o),
    .slv_r_data_o  (slv_r_data_o),
    .slv_r_resp_o  (slv_r_resp_o),
    .slv_r_last_o  (slv_r_last_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i),
    .tbl           (tbl_if.responder)
  );

endmodule

`default_nettype wire

/* design/r_unmap.sv */
`timescale 1ns/100ps
`default_nettype none

`include "id_remap_defines.svh"

module r_unmap (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  id_remap_pkg::remap_id_t  mst_r_id_i,
  input  id_remap_pkg::data_t      mst_r_data_i,
  input  id_remap_pkg::axi_resp_e  mst_r_resp_i,
  input  wire                      mst_r_last_i,
  input  wire                      mst_r_valid_i,
  output logic                     mst_r_ready_o,
  output id_remap_pkg::orig_id_t   slv_r_id_o,
  output id_remap_pkg::data_t      slv_r_data_o,
  output id_remap_pkg::axi_resp_e  slv_r_resp_o,
  output logic                     slv_r_last_o,
  output logic                     slv_r_valid_o,
  input  wire                      slv_r_ready_i,
  remap_table_if.responder         tbl
);

  logic                    out_valid_q;
  logic                    accept;
  id_remap_pkg::orig_id_t  id_q;
  id_remap_pkg::data_t     data_q;
  id_remap_pkg::axi_resp_e resp_q;
  logic                    last_q;

  assign mst_r_ready_o = !out_valid_q || slv_r_ready_i; // Empty or draining.
  assign accept        = mst_r_valid_i && mst_r_ready_o;

  // Only the slot bits of the narrow ID carry information.
  assign tbl.lookup_slot  = mst_r_id_i[`SLOT_W-1:0];
  assign tbl.release_slot = mst_r_id_i[`SLOT_W-1:0];
  assign tbl.release_req  = accept && mst_r_last_i; // Last beat frees the slot.

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_q <= 1'b0;
    end else if (accept) begin
      out_valid_q <= 1'b1;
    end else if (slv_r_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q   <= tbl.lookup_id;
      data_q <= mst_r_data_i;
      resp_q <= mst_r_resp_i;
      last_q <= mst_r_last_i;
    end
  end

  assign slv_r_valid_o = out_valid_q;
  assign slv_r_id_o    = id_q;
  assign slv_r_data_o  = data_q;
  assign slv_r_resp_o  = resp_q;
  assign slv_r_last_o  = last_q;

endmodule

`default_nettype wire

/* design/remap_table.sv */
`timescale 1ns/100ps
`default_nettype none

`include "id_remap_defines.svh"

module remap_table (
  input  wire               clk_i,
  input  wire               reset_i,
  remap_table_if.slot_table tbl
);

  id_remap_pkg::slot_state_e state_q [`N_SLOTS];
  id_remap_pkg::orig_id_t    id_q    [`N_SLOTS];

  logic                    id_hit;
  logic                    free_any;
  id_remap_pkg::slot_idx_t free_idx;

  // Walk from the top so the lowest free slot wins.
  always_comb begin
    id_hit   = 1'b0;
    free_any = 1'b0;
    free_idx = '0;
    for (int i = `N_SLOTS - 1; i >= 0; i--) begin
      if (state_q[i] == id_remap_pkg::SLOT_BUSY && id_q[i] == tbl.alloc_id) begin
        id_hit = 1'b1;
      end
      if (state_q[i] == id_remap_pkg::SLOT_FREE) begin
        free_any = 1'b1;
        free_idx = id_remap_pkg::slot_idx_t'(i);
      end
    end
  end

  assign tbl.alloc_gnt  = tbl.alloc_req && !id_hit && free_any;
  assign tbl.alloc_slot = free_idx;

  assign tbl.lookup_id = id_q[tbl.lookup_slot];

  // Grant takes only a free slot and release only a busy one.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `N_SLOTS; i++) begin
        state_q[i] <= id_remap_pkg::SLOT_FREE;
      end
    end else begin
      for (int i = 0; i < `N_SLOTS; i++) begin
        if (tbl.release_req && tbl.release_slot == id_remap_pkg::slot_idx_t'(i)) begin
          state_q[i] <= id_remap_pkg::SLOT_FREE;
        end
        if (tbl.alloc_gnt && tbl.alloc_slot == id_remap_pkg::slot_idx_t'(i)) begin
          state_q[i] <= id_remap_pkg::SLOT_BUSY;
        end
      end
    end
  end

  // Slot takes the original ID on grant.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `N_SLOTS; i++) begin
      if (tbl.alloc_gnt && tbl.alloc_slot == id_remap_pkg::slot_idx_t'(i)) begin
        id_q[i] <= tbl.alloc_id;
      end
    end
  end

endmodule

`default_nettype wire

/* design/ar_remap.sv */
`timescale 1ns/100ps
`default_nettype none

`include "id_remap_defines.svh"

module ar_remap (
  input  wire                       clk_i,
  input  wire                       reset_i,
  input  id_remap_pkg::orig_id_t    slv_ar_id_i,
  input  id_remap_pkg::in_addr_t    slv_ar_addr_i,
  input  wire [7:0]                 slv_ar_len_i,
  input  wire [2:0]                 slv_ar_size_i,
  input  id_remap_pkg::axi_burst_e  slv_ar_burst_i,
  input  wire [2:0]                 slv_ar_prot_i,
  input  wire                       slv_ar_valid_i,
  output logic                      slv_ar_ready_o,
  output id_remap_pkg::remap_id_t   mst_ar_id_o,
  output id_remap_pkg::out_addr_t   mst_ar_addr_o,
  output logic [7:0]                mst_ar_len_o,
  output logic [2:0]                mst_ar_size_o,
  output id_remap_pkg::axi_burst_e  mst_ar_burst_o,
  output logic [2:0]                mst_ar_prot_o,
  output logic                      mst_ar_valid_o,
  input  wire                       mst_ar_ready_i,
  remap_table_if.requester          tbl
);

  logic                     out_valid_q;
  logic                     out_free;
  logic                     accept;
  id_remap_pkg::remap_id_t  id_q;
  id_remap_pkg::out_addr_t  addr_q;
  logic [7:0]               len_q;
  logic [2:0]               size_q;
  id_remap_pkg::axi_burst_e burst_q;
  logic [2:0]               prot_q;

  // Output register is empty or drains this cycle.
  assign out_free = !out_valid_q || mst_ar_ready_i;

  assign tbl.alloc_req = slv_ar_valid_i && out_free;
  assign tbl.alloc_id  = slv_ar_id_i;

  // Grant covers ID clash, full table and output back-pressure.
  assign slv_ar_ready_o = tbl.alloc_gnt;
  assign accept         = slv_ar_valid_i && tbl.alloc_gnt;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_q <= 1'b0;
    end else if (accept) begin
      out_valid_q <= 1'b1;
    end else if (mst_ar_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q    <= {{(`REMAP_ID_W-`SLOT_W){1'b0}}, tbl.alloc_slot}; // Slot becomes the new ID.
      addr_q  <= {{(`OUT_ADDR_W-`IN_ADDR_W){1'b0}}, slv_ar_addr_i};
      len_q   <= slv_ar_len_i;
      size_q  <= slv_ar_size_i;
      burst_q <= slv_ar_burst_i;
      prot_q  <= slv_ar_prot_i;
    end
  end

  assign mst_ar_valid_o = out_valid_q;
  assign mst_ar_id_o    = id_q;
  assign mst_ar_addr_o  = addr_q;
  assign mst_ar_len_o   = len_q;
  assign mst_ar_size_o  = size_q;
  assign mst_ar_burst_o = burst_q;
  assign mst_ar_prot_o  = prot_q;

endmodule

`default_nettype wire

/* design/remap_table_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface remap_table_if;

  // Allocation by the request path.
  logic                   alloc_req;
  id_remap_pkg::orig_id_t alloc_id;
  logic                    alloc_gnt;
  id_remap_pkg::slot_idx_t alloc_slot;

  // Lookup and release by the response path.
  id_remap_pkg::slot_idx_t lookup_slot;
  id_remap_pkg::orig_id_t  lookup_id;
  logic                    release_req; // Single-cycle pulse.
  id_remap_pkg::slot_idx_t release_slot;

  modport requester (
    output alloc_req, alloc_id,
    input  alloc_gnt, alloc_slot
  );

  modport slot_table (
    input  alloc_req, alloc_id, lookup_slot, release_req, release_slot,
    output alloc_gnt, alloc_slot, lookup_id
  );

  modport responder (
    output lookup_slot, release_req, release_slot,
    input  lookup_id
  );

endinterface

`default_nettype wire

/* design/id_remap_pkg.sv */
`default_nettype none

`include "id_remap_defines.svh"

package id_remap_pkg;

  typedef logic [`ORIG_ID_W-1:0]  orig_id_t;
  typedef logic [`REMAP_ID_W-1:0] remap_id_t;
  typedef logic [`SLOT_W-1:0]     slot_idx_t;
  typedef logic [`IN_ADDR_W-1:0]  in_addr_t;
  typedef logic [`OUT_ADDR_W-1:0] out_addr_t;
  typedef logic [`DATA_W-1:0]     data_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic {
    SLOT_FREE = 1'b0,
    SLOT_BUSY = 1'b1
  } slot_state_e;

endpackage

`default_nettype wire

/* include/id_remap_defines.svh */
`ifndef ID_REMAP_DEFINES_SVH
`define ID_REMAP_DEFINES_SVH

// Upstream and downstream ID widths.
`define ORIG_ID_W  17
`define REMAP_ID_W 4

// Address is zero-extended from IN to OUT width.
`define IN_ADDR_W  40
`define OUT_ADDR_W 64

`define DATA_W     128

// One transaction per ID, four unique IDs in flight.
`define N_SLOTS    4
`define SLOT_W     2

`endif
